// ==== Bender.yml ====
package:
  name: msx_slots

sources:
  - hw/msx_slot_pkg.sv
  - hw/msx_mem_pkg.sv
  - hw/xlat_if.sv
  - hw/slot_expander.sv
  - hw/ram_mapper.sv
  - hw/page_map.sv
  - hw/mem_port.sv
  - hw/msx_slots.sv
  - target: test
    files:
      - dv/msx_slots_assertions.sv
      - dv/msx_slots_tb.sv

// ==== dv/msx_slots_assertions.sv ====
module msx_slots_assertions (
   input logic                   clk,
   input logic                   reset,
   input logic                   cpu_valid,
   input logic                   cpu_ready,
   input logic                   cfg_ready,
   input logic                   mem_valid,
   input logic                   mem_ready,
   input logic                   mem_rvalid,
   input logic                   mem_we,
   input msx_mem_pkg::mem_addr_t mem_addr,
   input msx_mem_pkg::byte_t     mem_wdata
);

   int fail_count = 0;   // Polled by the testbench

   mem_hold: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=>
         mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
      else begin
         fail_count++;
         $error("memory request changed before mem_ready");
      end

   ready_pulse: assert property (@(posedge clk) disable iff (reset)
      cpu_ready |=> !cpu_ready)
      else begin
         fail_count++;
         $error("cpu_ready held longer than one cycle");
      end

   reset_quiet: assert property (@(posedge clk)
      reset |-> !cpu_ready && !cfg_ready && !mem_valid && !mem_we)
      else begin
         fail_count++;
         $error("control output high during reset");
      end

   cfg_blocked: assert property (@(posedge clk) disable iff (reset)
      cpu_valid || cpu_ready |-> !cfg_ready)
      else begin
         fail_count++;
         $error("cfg_ready high during a CPU transaction");
      end

   // Register and null accesses reply at once, memory accesses request at once
   first_step: assert property (@(posedge clk) disable iff (reset)
      $rose(cpu_valid) |=> cpu_ready || mem_valid)
      else begin
         fail_count++;
         $error("no reply and no memory request one cycle after cpu_valid");
      end

   write_end: assert property (@(posedge clk) disable iff (reset)
      mem_valid && mem_ready && mem_we |=> cpu_ready)
      else begin
         fail_count++;
         $error("write did not end one cycle after mem_ready");
      end

   read_end: assert property (@(posedge clk) disable iff (reset)
      mem_rvalid |=> cpu_ready)
      else begin
         fail_count++;
         $error("read did not end one cycle after mem_rvalid");
      end

endmodule

bind msx_slots msx_slots_assertions assertions_i (
   .clk(clk), .reset(reset), .cpu_valid(cpu_valid), .cpu_ready(cpu_ready),
   .cfg_ready(cfg_ready), .mem_valid(mem_valid), .mem_ready(mem_ready),
   .mem_rvalid(mem_rvalid), .mem_we(mem_we),
   .mem_addr(mem_addr), .mem_wdata(mem_wdata)
);

// ==== dv/msx_slots_tb.sv ====
module msx_slots_tb;

   localparam logic [3:0] EXP_MASK = 4'b1010;
   localparam int TXN_BUDGET = 120;

   logic clk, reset, cpu_valid, cpu_ready, cpu_wr, cpu_iorq, cfg_valid, cfg_ready;
   logic mem_valid, mem_ready, mem_we, mem_rvalid;
   logic [15:0] cpu_addr;
   logic [7:0] cpu_wdata, cpu_rdata, mem_wdata, mem_rdata, cfg_block;
   logic [1:0] active_slot;
   logic [5:0] cfg_index;
   logic [21:0] mem_addr, last_addr;
   logic last_we;
   logic [7:0] last_wdata;
   msx_slot_pkg::slot_typ_t cfg_typ;
   int req_count = 0;

   logic [7:0] mem [0:(1<<22)-1];
   logic [7:0] ref_mem [int];
   msx_slot_pkg::slot_typ_t tbl_typ [64];
   logic [7:0] tbl_block [64];
   logic tbl_init [64] = '{default: 1'b0};
   logic [7:0] exp_regs [4] = '{default: 8'h00};
   logic [7:0] banks [4] = '{8'd3, 8'd2, 8'd1, 8'd0};

   msx_slots #(.EXPANDED_MASK(EXP_MASK)) msx_slots_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [7:0] fill_byte(input logic [21:0] a);
      return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'h5A;
   endfunction

   function automatic logic [7:0] ref_byte(input logic [21:0] a);
      return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   // Memory model with random ready and read latency
   always begin
      @(negedge clk);
      if (!reset && mem_valid) begin
         repeat ($urandom_range(0, 3)) @(negedge clk);
         last_addr  = mem_addr;
         last_we    = mem_we;
         last_wdata = mem_wdata;
         req_count++;
         mem_ready = 1'b1;
         @(negedge clk);
         mem_ready = 1'b0;
         if (last_we) begin
            mem[last_addr] = last_wdata;
         end else begin
            repeat ($urandom_range(1, 3) - 1) @(negedge clk);
            mem_rdata = mem[last_addr];
            mem_rvalid = 1'b1;
            @(negedge clk);
            mem_rvalid = 1'b0;
         end
      end
   end

   always @(negedge clk) begin
      if (msx_slots_i.assertions_i.fail_count != 0) begin
         fail_run("A protocol assertion failed");
      end
   end

   initial begin
      #(TXN_BUDGET * 400 * 10);
      fail_run("Timeout, the DUT stopped answering");
   end

   task automatic load_entry(input logic [5:0] idx, input msx_slot_pkg::slot_typ_t typ,
                             input logic [7:0] blk);
      @(negedge clk);
      cfg_valid = 1'b1;
      cfg_index = idx;
      cfg_typ   = typ;
      cfg_block = blk;
      #1;
      while (!cfg_ready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);   // Taken on the posedge in between
      cfg_valid = 1'b0;
      tbl_typ[idx]   = typ;
      tbl_block[idx] = blk;
      tbl_init[idx]  = 1'b1;
   endtask

   task automatic cpu_access(input logic io, input logic wr, input logic [15:0] addr,
                             input logic [7:0] wdata, input logic [1:0] slot);
      logic [1:0] page;
      logic [1:0] sub;
      logic [5:0] idx;
      logic exp_hit, map_hit, is_mem;
      logic [7:0] blk, expected;
      logic [21:0] ea;
      int reqs;
      page    = addr[15:14];
      exp_hit = !io && addr == 16'hFFFF && EXP_MASK[slot];
      map_hit = io && addr[7:2] == 6'h3F;
      sub     = EXP_MASK[slot] ? exp_regs[slot][2*page +: 2] : 2'd0;
      idx     = {slot, sub, page};
      blk     = tbl_block[idx];
      if (tbl_typ[idx] == msx_slot_pkg::PAGE_MAPPER) blk = blk + banks[page];
      ea      = {blk, addr[13:0]};
      is_mem  = !io && !exp_hit && tbl_init[idx] && tbl_typ[idx] != msx_slot_pkg::PAGE_EMPTY &&
                (!wr || tbl_typ[idx] inside {msx_slot_pkg::PAGE_RAM, msx_slot_pkg::PAGE_MAPPER});
      expected = exp_hit ? ~exp_regs[slot] : map_hit ? banks[addr[1:0]] :
                 is_mem ? ref_byte(ea) : 8'hFF;
      reqs = req_count;
      @(negedge clk);
      cpu_valid = 1'b1;
      cpu_iorq = io;
      cpu_wr = wr;
      cpu_addr = addr;
      cpu_wdata = wdata;
      active_slot = slot;
      do @(negedge clk); while (!cpu_ready);
      cpu_valid = 1'b0;
      if (!wr) check_value("cpu_rdata", cpu_rdata, expected);
      check_value("memory request count", req_count - reqs, is_mem);
      if (is_mem) check_value("mem_addr", last_addr, ea);
      if (wr && exp_hit) exp_regs[slot] = wdata;
      else if (wr && map_hit) banks[addr[1:0]] = wdata;
      else if (wr && is_mem) ref_mem[ea] = wdata;
   endtask

   initial begin
      void'($urandom(32'h62df_aac6));
      for (int a = 0; a < (1 << 22); a++) mem[a] = fill_byte(a);
      {reset, cpu_valid, cpu_wr, cpu_iorq, cfg_valid, mem_ready, mem_rvalid} = '0;
      {cpu_addr, cpu_wdata, active_slot, cfg_index, cfg_block, mem_rdata} = '0;
      cfg_typ = msx_slot_pkg::PAGE_EMPTY;
      #1 reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk) reset = 1'b0;

      load_entry(6'b00_00_00, msx_slot_pkg::PAGE_ROM, 8'h10);
      load_entry(6'b00_00_01, msx_slot_pkg::PAGE_RAM, 8'h20);
      load_entry(6'b00_00_10, msx_slot_pkg::PAGE_RAM, 8'h21);
      load_entry(6'b00_00_11, msx_slot_pkg::PAGE_MAPPER, 8'h40);
      load_entry(6'b10_00_01, msx_slot_pkg::PAGE_RAM, 8'h30);
      load_entry(6'b10_00_10, msx_slot_pkg::PAGE_ROM, 8'h31);
      load_entry(6'b10_00_11, msx_slot_pkg::PAGE_EMPTY, 8'h32);
      load_entry(6'b01_01_01, msx_slot_pkg::PAGE_RAM, 8'h50);
      load_entry(6'b01_10_10, msx_slot_pkg::PAGE_RAM, 8'h51);
      load_entry(6'b01_00_01, msx_slot_pkg::PAGE_ROM, 8'h52);
      load_entry(6'b11_11_00, msx_slot_pkg::PAGE_MAPPER, 8'h60);

      // RAM, ROM and null accesses
      cpu_access(0, 1, 16'h4123, 8'hA5, 0);
      cpu_access(0, 1, 16'h8001, 8'h3C, 0);
      cpu_access(0, 1, 16'h7FFE, 8'h77, 2);
      cpu_access(0, 0, 16'h4123, 0, 0);
      cpu_access(0, 0, 16'h8001, 0, 0);
      cpu_access(0, 0, 16'h7FFE, 0, 2);
      cpu_access(0, 0, 16'h0234, 0, 0);
      cpu_access(0, 1, 16'h0234, 8'h11, 0);
      cpu_access(0, 0, 16'h0234, 0, 0);
      cpu_access(0, 0, 16'h9000, 0, 2);
      cpu_access(0, 0, 16'h1000, 0, 2);
      cpu_access(0, 0, 16'hC000, 0, 2);
      cpu_access(1, 0, 16'h0098, 0, 0);

      // Expanded slots
      cpu_access(0, 0, 16'hFFFF, 0, 1);
      cpu_access(0, 0, 16'h4000, 0, 1);
      cpu_access(0, 1, 16'hFFFF, 8'h24, 1);
      cpu_access(0, 0, 16'hFFFF, 0, 1);
      cpu_access(0, 1, 16'h4444, 8'h5E, 1);
      cpu_access(0, 1, 16'h8888, 8'hE5, 1);
      cpu_access(0, 0, 16'h4444, 0, 1);
      cpu_access(0, 0, 16'h8888, 0, 1);
      cpu_access(0, 1, 16'hFFFF, 8'h03, 3);
      cpu_access(0, 0, 16'hFFFF, 0, 3);
      cpu_access(0, 0, 16'h0010, 0, 3);

      // Mapper registers and banked pages
      for (int p = 0; p < 4; p++) cpu_access(1, 0, 16'h00FC + p, 0, 0);
      cpu_access(1, 1, 16'h00FF, 8'h05, 0);
      cpu_access(1, 1, 16'h00FC, 8'hC7, 0);
      cpu_access(1, 0, 16'h00FF, 0, 0);
      cpu_access(0, 1, 16'hC123, 8'h99, 0);
      cpu_access(0, 0, 16'hC123, 0, 0);
      cpu_access(0, 0, 16'h0321, 0, 3);

      // Table load racing a transaction
      fork
         cpu_access(0, 0, 16'h4010, 0, 0);
         load_entry(6'b10_00_00, msx_slot_pkg::PAGE_RAM, 8'h33);
      join
      cpu_access(0, 0, 16'h0100, 0, 2);

      repeat (40) begin
         cpu_access($urandom_range(0, 7) == 0, $urandom_range(0, 1), $urandom,
                    $urandom, $urandom_range(0, 3));
      end

      repeat (4) @(negedge clk);
      if (msx_slots_i.assertions_i.fail_count != 0) begin
         fail_run("A protocol assertion failed");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// ==== hw/mem_port.sv ====
module mem_port (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cpu_valid,
   input  logic                   cpu_wr,
   input  logic                   cpu_iorq,
   input  msx_mem_pkg::byte_t     cpu_wdata,
   input  logic                   exp_hit,
   input  msx_mem_pkg::byte_t     exp_rdata,
   input  logic                   map_hit,
   input  msx_mem_pkg::byte_t     map_rdata,
   xlat_if.port                   xlat,
   input  logic                   mem_ready,
   input  msx_mem_pkg::byte_t     mem_rdata,
   input  logic                   mem_rvalid,
   output logic                   cpu_ready,
   output msx_mem_pkg::byte_t     cpu_rdata,
   output logic                   accept,
   output logic                   busy,
   output logic                   mem_valid,
   output msx_mem_pkg::mem_addr_t mem_addr,
   output logic                   mem_we,
   output msx_mem_pkg::byte_t     mem_wdata
);

   typedef enum logic [2:0] {IDLE, REPLY, REQ, WAIT_DATA, DONE} state_t;

   state_t state;
   logic   reg_acc;
   logic   mem_acc;
   logic   we_q;

   assign reg_acc = exp_hit || map_hit;
   // Anything else is a null access, answered with FF
   assign mem_acc = !cpu_iorq && xlat.init && xlat.typ != msx_slot_pkg::PAGE_EMPTY &&
                    (!cpu_wr || xlat.writable);

   assign accept    = state == IDLE && cpu_valid;
   assign busy      = cpu_valid || state != IDLE;
   assign cpu_ready = state == REPLY || state == DONE;
   assign mem_valid = state == REQ;
   assign mem_we    = mem_valid && we_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (cpu_valid) begin
                  state <= (!reg_acc && mem_acc) ? REQ : REPLY;
               end
            end
            REQ: begin
               if (mem_ready) begin
                  state <= we_q ? DONE : WAIT_DATA;
               end
            end
            WAIT_DATA: begin
               if (mem_rvalid) begin
                  state <= DONE;
               end
            end
            default: state <= IDLE;   // REPLY and DONE last one cycle
         endcase
      end
   end

   // Request fields and read byte, captured at accept
   always_ff @(posedge clk) begin
      if (accept) begin
         mem_addr  <= xlat.addr;
         mem_wdata <= cpu_wdata;
         we_q      <= cpu_wr;
         cpu_rdata <= exp_hit ? exp_rdata : map_hit ? map_rdata : 8'hFF;
      end else if (state == WAIT_DATA && mem_rvalid) begin
         cpu_rdata <= mem_rdata;
      end
   end

endmodule

// ==== hw/msx_mem_pkg.sv ====
package msx_mem_pkg;

   typedef logic [15:0] cpu_addr_t;

   typedef logic [7:0] byte_t;

   // 16 KB block in external memory
   typedef logic [7:0] block_t;

   // {block, 14 bit offset}
   typedef logic [21:0] mem_addr_t;

endpackage

// ==== hw/msx_slot_pkg.sv ====
package msx_slot_pkg;

   // Kind of memory behind one page of one (sub)slot
   typedef enum logic [2:0] {
      PAGE_EMPTY  = 3'd0,
      PAGE_ROM    = 3'd1,
      PAGE_RAM    = 3'd2,
      PAGE_MAPPER = 3'd3   // RAM banked through ports FC..FF
   } slot_typ_t;

   // Primary slot, selected outside the design
   typedef logic [1:0] slot_t;

   // Secondary slot from the expander register at FFFF
   typedef logic [1:0] subslot_t;

   // CPU page, address bits 15:14
   typedef logic [1:0] page_t;

   // Page table index, {slot, subslot, page}
   typedef logic [5:0] tbl_index_t;

endpackage

// ==== hw/msx_slots.sv ====
module msx_slots #(
   parameter logic [3:0] EXPANDED_MASK = 4'b0000
) (
   input  logic                      clk,
   input  logic                      reset,
   // CPU side
   input  logic                      cpu_valid,
   output logic                      cpu_ready,
   input  msx_mem_pkg::cpu_addr_t    cpu_addr,
   input  msx_mem_pkg::byte_t        cpu_wdata,
   output msx_mem_pkg::byte_t        cpu_rdata,
   input  logic                      cpu_wr,
   input  logic                      cpu_iorq,
   input  msx_slot_pkg::slot_t       active_slot,
   // Page table load
   input  logic                      cfg_valid,
   output logic                      cfg_ready,
   input  msx_slot_pkg::tbl_index_t  cfg_index,
   input  msx_slot_pkg::slot_typ_t   cfg_typ,
   input  msx_mem_pkg::block_t       cfg_block,
   // External memory
   output logic                      mem_valid,
   input  logic                      mem_ready,
   output msx_mem_pkg::mem_addr_t    mem_addr,
   output logic                      mem_we,
   output msx_mem_pkg::byte_t        mem_wdata,
   input  msx_mem_pkg::byte_t        mem_rdata,
   input  logic                      mem_rvalid
);

   msx_slot_pkg::subslot_t subslot;
   msx_mem_pkg::block_t    bank;
   msx_mem_pkg::byte_t     exp_rdata;
   msx_mem_pkg::byte_t     map_rdata;
   logic                   exp_hit;
   logic                   map_hit;
   logic                   accept;
   logic                   busy;

   xlat_if xlat ();

   slot_expander #(
      .EXPANDED_MASK(EXPANDED_MASK)
   ) slot_expander_i (
      .clk(clk), .reset(reset), .accept(accept),
      .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wr(cpu_wr), .cpu_iorq(cpu_iorq),
      .active_slot(active_slot), .subslot(subslot),
      .reg_hit(exp_hit), .reg_rdata(exp_rdata)
   );

   ram_mapper ram_mapper_i (
      .clk(clk), .reset(reset), .accept(accept),
      .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wr(cpu_wr), .cpu_iorq(cpu_iorq),
      .bank(bank), .reg_hit(map_hit), .reg_rdata(map_rdata)
   );

   page_map page_map_i (
      .clk(clk), .reset(reset),
      .cfg_valid(cfg_valid), .cfg_index(cfg_index), .cfg_typ(cfg_typ),
      .cfg_block(cfg_block), .busy(busy), .active_slot(active_slot),
      .subslot(subslot), .cpu_addr(cpu_addr), .bank(bank),
      .cfg_ready(cfg_ready), .xlat(xlat.map)
   );

   mem_port mem_port_i (
      .clk(clk), .reset(reset),
      .cpu_valid(cpu_valid), .cpu_wr(cpu_wr), .cpu_iorq(cpu_iorq), .cpu_wdata(cpu_wdata),
      .exp_hit(exp_hit), .exp_rdata(exp_rdata), .map_hit(map_hit), .map_rdata(map_rdata),
      .xlat(xlat.port),
      .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid),
      .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata), .accept(accept), .busy(busy),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata)
   );

endmodule

// ==== hw/page_map.sv ====
module page_map (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      cfg_valid,
   input  msx_slot_pkg::tbl_index_t  cfg_index,
   input  msx_slot_pkg::slot_typ_t   cfg_typ,
   input  msx_mem_pkg::block_t       cfg_block,
   input  logic                      busy,
   input  msx_slot_pkg::slot_t       active_slot,
   input  msx_slot_pkg::subslot_t    subslot,
   input  msx_mem_pkg::cpu_addr_t    cpu_addr,
   input  msx_mem_pkg::block_t       bank,
   output logic                      cfg_ready,
   xlat_if.map                       xlat
);

   localparam int ENTRIES = 2 ** $bits(msx_slot_pkg::tbl_index_t);

   msx_slot_pkg::slot_typ_t  ent_typ   [ENTRIES];
   msx_mem_pkg::block_t      ent_block [ENTRIES];
   logic [ENTRIES-1:0]       ent_init;
   logic                     run_q;
   logic                     load;
   msx_slot_pkg::tbl_index_t idx;
   msx_mem_pkg::block_t      blk;

   // Table is frozen while a CPU transaction runs
   assign cfg_ready = run_q && !busy;
   assign load      = cfg_valid && cfg_ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         run_q    <= 1'b0;
         ent_init <= '0;
      end else begin
         run_q <= 1'b1;
         if (load) begin
            ent_init[cfg_index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         ent_typ[cfg_index]   <= cfg_typ;
         ent_block[cfg_index] <= cfg_block;
      end
   end

   assign idx = {active_slot, subslot, cpu_addr[15:14]};

   // Mapper pages add the bank, wrapping at 256 blocks
   assign blk = (ent_typ[idx] == msx_slot_pkg::PAGE_MAPPER) ? ent_block[idx] + bank
                                                             : ent_block[idx];

   assign xlat.typ      = ent_typ[idx];
   assign xlat.addr     = {blk, cpu_addr[13:0]};
   assign xlat.init     = ent_init[idx];
   assign xlat.writable = ent_typ[idx] == msx_slot_pkg::PAGE_RAM ||
                          ent_typ[idx] == msx_slot_pkg::PAGE_MAPPER;

endmodule

// ==== hw/ram_mapper.sv ====
module ram_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   accept,
   input  msx_mem_pkg::cpu_addr_t cpu_addr,
   input  msx_mem_pkg::byte_t     cpu_wdata,
   input  logic                   cpu_wr,
   input  logic                   cpu_iorq,
   output msx_mem_pkg::block_t    bank,
   output logic                   reg_hit,
   output msx_mem_pkg::byte_t     reg_rdata
);

   msx_mem_pkg::block_t bank_reg [4];
   msx_slot_pkg::page_t port_sel;
   msx_slot_pkg::page_t page;

   assign port_sel = cpu_addr[1:0];   // FC..FF map to pages 0..3
   assign page     = cpu_addr[15:14];

   assign reg_hit   = cpu_iorq && cpu_addr[7:2] == 6'b111111;
   assign reg_rdata = bank_reg[port_sel];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         // Power-on layout, page 0 on the top bank
         bank_reg[0] <= 8'd3;
         bank_reg[1] <= 8'd2;
         bank_reg[2] <= 8'd1;
         bank_reg[3] <= 8'd0;
      end else if (accept && reg_hit && cpu_wr) begin
         bank_reg[port_sel] <= cpu_wdata;
      end
   end

   assign bank = bank_reg[page];   // Only meaningful for memory accesses

endmodule

// ==== hw/slot_expander.sv ====
module slot_expander #(
   parameter logic [3:0] EXPANDED_MASK = 4'b0000
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    accept,
   input  msx_mem_pkg::cpu_addr_t  cpu_addr,
   input  msx_mem_pkg::byte_t      cpu_wdata,
   input  logic                    cpu_wr,
   input  logic                    cpu_iorq,
   input  msx_slot_pkg::slot_t     active_slot,
   output msx_slot_pkg::subslot_t  subslot,
   output logic                    reg_hit,
   output msx_mem_pkg::byte_t      reg_rdata
);

   msx_mem_pkg::byte_t  sub_reg [4];   // One per primary slot
   msx_slot_pkg::page_t page;
   logic                expanded;

   assign page     = cpu_addr[15:14];
   assign expanded = EXPANDED_MASK[active_slot];

   // FFFF only decodes as register in an expanded slot
   assign reg_hit   = expanded && !cpu_iorq && cpu_addr == 16'hFFFF;
   assign reg_rdata = ~sub_reg[active_slot];   // Reads back inverted

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            sub_reg[i] <= '0;
         end
      end else if (accept && reg_hit && cpu_wr) begin
         sub_reg[active_slot] <= cpu_wdata;
      end
   end

   // Two bits per page, page 0 in the low bits
   assign subslot = expanded ? sub_reg[active_slot][2*page +: 2] : '0;

endmodule

// ==== hw/xlat_if.sv ====
interface xlat_if;

   msx_slot_pkg::slot_typ_t typ;       // Page type of current access
   msx_mem_pkg::mem_addr_t  addr;      // Translated byte address
   logic                    init;      // Entry loaded since reset
   logic                    writable;  // RAM or MAPPER

   modport map (
      output typ,
      output addr,
      output init,
      output writable
   );

   modport port (
      input typ,
      input addr,
      input init,
      input writable
   );

endinterface

// ==== vlog.f ====
hw/msx_slot_pkg.sv
hw/msx_mem_pkg.sv
hw/xlat_if.sv
hw/slot_expander.sv
hw/ram_mapper.sv
hw/page_map.sv
hw/mem_port.sv
hw/msx_slots.sv
dv/msx_slots_assertions.sv
dv/msx_slots_tb.sv
